// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module pipeTb -Mdir obj_dir -f src.f
	./obj_dir/VpipeTb | tee sim.log
	@if grep -q "tests failed" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "all tests passed" sim.log || { echo "simulation ended early"; exit 1; }

clean:
	rm -rf obj_dir sim.log

// ==== design/backEnd.sv ====
`timescale 1ns/10ps

module backEnd (
    input  logic                 clk,
    input  logic                 reset,
    input  pipeCtrlPkg::hazCtrl  ctl,
    input  pipeCtrlPkg::stageTok iTok,
    input  pipeCtrlPkg::pcT      branchPc,
    input  pipeCtrlPkg::pcT      branchTarget,
    input  pipeCtrlPkg::pcT      excpPc,
    input  logic                 irq,
    output logic                 branchM,
    output logic                 excpM,
    output logic                 excpW,
    output logic                 redirValid,
    output pipeCtrlPkg::pcT      redirPc,
    output logic                 retireValid,
    output pipeCtrlPkg::pcT      retirePc
);

    pipeCtrlPkg::stageTok eTok;
    pipeCtrlPkg::stageTok mTok;
    pipeCtrlPkg::stageTok m2Tok;
    pipeCtrlPkg::stageTok m3Tok;
    pipeCtrlPkg::stageTok wTok;

    // ##################################################
    // events seen in M and W
    // ##################################################
    assign excpM   = mTok.valid && (mTok.pc == excpPc);
    assign branchM = mTok.valid && (mTok.pc == branchPc) && !excpM;
    assign excpW   = irq && wTok.valid;            // interrupts are taken on a live W token

    assign redirValid = excpW || excpM || branchM;

    always_comb begin
        if (excpW || excpM) begin
            redirPc = pipeCtrlPkg::EXCP_VECTOR;
        end else begin
            redirPc = branchTarget;
        end
    end

    // ##################################################
    // stage registers
    // ##################################################
    always_ff @(posedge clk) begin
        if (reset) begin
            eTok.valid  <= 1'b0;
            mTok.valid  <= 1'b0;
            m2Tok.valid <= 1'b0;
            m3Tok.valid <= 1'b0;
            wTok.valid  <= 1'b0;
        end else begin
            eTok  <= pipeCtrlPkg::stageNext(eTok, iTok, !ctl.stallIDe, ctl.stallE, ctl.flushE);
            mTok  <= pipeCtrlPkg::stageNext(mTok, eTok, !ctl.stallE, ctl.stallM, ctl.flushM);
            // a faulting M token never reaches M2
            m2Tok <= pipeCtrlPkg::stageNext(m2Tok, mTok, !ctl.stallM && !excpM,
                                            ctl.stallM2, ctl.flushM2);
            m3Tok <= pipeCtrlPkg::stageNext(m3Tok, m2Tok, !ctl.stallM2, 1'b0, ctl.flushM3);
            wTok  <= pipeCtrlPkg::stageNext(wTok, m3Tok, 1'b1, 1'b0, ctl.flushW);  // no stall here
        end
    end

    // interrupted W token is dropped and not retired
    assign retireValid = wTok.valid && !excpW;
    assign retirePc    = wTok.pc;

endmodule

// ==== design/decodeIssue.sv ====
`timescale 1ns/10ps

module decodeIssue (
    input  logic                 clk,
    input  logic                 reset,
    input  pipeCtrlPkg::hazCtrl  ctl,
    input  pipeCtrlPkg::stageTok f3Tok,
    output pipeCtrlPkg::stageTok iTok,
    output logic                 overflowI
);

    pipeCtrlPkg::stageTok dTok;
    pipeCtrlPkg::pcT      qMem [pipeCtrlPkg::QUEUE_DEPTH];
    pipeCtrlPkg::qPtrT    rdPtr;
    pipeCtrlPkg::qPtrT    wrPtr;
    pipeCtrlPkg::qCntT    count;
    logic                 qEmpty;
    logic                 pushReq;
    logic                 popEn;
    logic                 bypass;
    logic                 qWrite;
    logic                 qRead;

    assign qEmpty    = (count == '0);
    assign overflowI = (count == pipeCtrlPkg::qCntT'(pipeCtrlPkg::QUEUE_DEPTH));

    assign pushReq = dTok.valid && !ctl.stallI && !ctl.flushQue;
    assign popEn   = !ctl.stallIDe;
    assign bypass  = pushReq && popEn && qEmpty;    // empty queue lets D go straight to I
    assign qWrite  = pushReq && !bypass;
    assign qRead   = popEn && !qEmpty && !ctl.flushQue;

    // decode register
    always_ff @(posedge clk) begin
        if (reset) begin
            dTok.valid <= 1'b0;
        end else begin
            dTok <= pipeCtrlPkg::stageNext(dTok, f3Tok, !ctl.stallF3, ctl.stallD, ctl.flushD);
        end
    end

    // ##################################################
    // issue queue
    // ##################################################
    always_ff @(posedge clk) begin
        if (qWrite) begin
            qMem[wrPtr] <= dTok.pc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || ctl.flushQue) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (qWrite) begin
                wrPtr <= (wrPtr == pipeCtrlPkg::qPtrT'(pipeCtrlPkg::QUEUE_DEPTH - 1)) ?
                         '0 : wrPtr + 1'b1;
            end
            if (qRead) begin
                rdPtr <= (rdPtr == pipeCtrlPkg::qPtrT'(pipeCtrlPkg::QUEUE_DEPTH - 1)) ?
                         '0 : rdPtr + 1'b1;
            end
            case ({qWrite, qRead})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // issued token register
    always_ff @(posedge clk) begin
        if (reset) begin
            iTok.valid <= 1'b0;
        end else if (ctl.flushI) begin
            iTok.valid <= 1'b0;
        end else if (popEn) begin
            iTok.valid <= qRead || bypass;
            iTok.pc    <= qEmpty ? dTok.pc : qMem[rdPtr];
        end
    end

endmodule

// ==== design/fetchUnit.sv ====
`timescale 1ns/10ps

module fetchUnit (
    input  logic                 clk,
    input  logic                 reset,
    input  pipeCtrlPkg::hazCtrl  ctl,
    input  logic                 redirValid,
    input  pipeCtrlPkg::pcT      redirPc,
    input  logic                 iWait,
    output pipeCtrlPkg::stageTok f3Tok
);

    pipeCtrlPkg::stageTok f2Tok;     // address presented to the instruction memory
    pipeCtrlPkg::stageTok pendTok;   // redirect parked while F2 is held
    pipeCtrlPkg::pcT      seqPc;
    logic                 takeRedir;
    logic                 f2Go;

    // a redirect only counts in a cycle where the hazard unit acts on it
    assign takeRedir = redirValid && ctl.flushF2;

    // an empty F2 slot refetches its pc instead of skipping it
    assign seqPc = f2Tok.valid ? f2Tok.pc + pipeCtrlPkg::PC_STEP : f2Tok.pc;

    // F2 hands its token over only when the memory has answered
    assign f2Go = !ctl.stallF2 && !iWait && !ctl.flushF2;

    // ##################################################
    // pc generator and F2
    // ##################################################
    always_ff @(posedge clk) begin
        if (reset) begin
            f2Tok.valid   <= 1'b0;
            f2Tok.pc      <= pipeCtrlPkg::RESET_PC;
            pendTok.valid <= 1'b0;
        end else if (takeRedir && ctl.stallF) begin
            f2Tok.valid   <= 1'b0;          // flush wins over the stall
            pendTok.valid <= 1'b1;
            pendTok.pc    <= redirPc;
        end else if (takeRedir) begin
            f2Tok.valid   <= 1'b1;
            f2Tok.pc      <= redirPc;
            pendTok.valid <= 1'b0;
        end else if (!ctl.stallF) begin
            f2Tok.valid   <= 1'b1;
            pendTok.valid <= 1'b0;
            if (pendTok.valid) begin
                f2Tok.pc <= pendTok.pc;     // parked target goes out first
            end else begin
                f2Tok.pc <= seqPc;
            end
        end
    end

    // ##################################################
    // F3
    // ##################################################
    always_ff @(posedge clk) begin
        if (reset) begin
            f3Tok.valid <= 1'b0;
        end else begin
            f3Tok <= pipeCtrlPkg::stageNext(f3Tok, f2Tok, f2Go, ctl.stallF3, ctl.flushF3);
        end
    end

endmodule

// ==== design/hazard.sv ====
`timescale 1ns/10ps

module hazard (
    input  logic                clk,
    input  logic                reset,
    input  logic                iWait,
    input  logic                dWait,
    input  logic                eWait,
    input  logic                overflowI,
    input  logic                branchM,
    input  logic                excpM,
    input  logic                excpW,
    output pipeCtrlPkg::hazCtrl ctl
);

    pipeCtrlPkg::redirState state;      // a redirect that met an instruction-memory wait
    pipeCtrlPkg::redirState stateNxt;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= pipeCtrlPkg::IDLE;
        end else begin
            state <= stateNxt;
        end
    end

    // ##################################################
    // priority chain, highest first
    // ##################################################
    always_comb begin
        ctl      = '0;
        stateNxt = state;
        if (excpW || excpM) begin
            ctl.flushF2  = 1'b1;
            ctl.flushF3  = 1'b1;
            ctl.flushD   = 1'b1;
            ctl.flushI   = 1'b1;
            ctl.flushQue = 1'b1;
            ctl.flushE   = 1'b1;
            ctl.flushM   = 1'b1;
            if (excpW) begin                // the whole back end is younger than W
                ctl.flushM2 = 1'b1;
                ctl.flushM3 = 1'b1;
                ctl.flushW  = 1'b1;
            end
            if (iWait) begin
                ctl.stallF  = 1'b1;
                ctl.stallF2 = 1'b1;
                stateNxt    = pipeCtrlPkg::EXCP_PEND;
            end
        end else if (dWait) begin
            ctl.stallF   = 1'b1;
            ctl.stallF2  = 1'b1;
            ctl.stallF3  = 1'b1;
            ctl.stallD   = 1'b1;
            ctl.stallI   = 1'b1;
            ctl.stallIDe = 1'b1;
            ctl.stallE   = 1'b1;
            ctl.stallM   = 1'b1;
            ctl.stallM2  = 1'b1;
            ctl.flushM3  = 1'b1;            // W sees a bubble behind the waiting load
        end else if (branchM) begin
            // the branch itself carries on into M2
            ctl.flushF2  = 1'b1;
            ctl.flushF3  = 1'b1;
            ctl.flushD   = 1'b1;
            ctl.flushI   = 1'b1;
            ctl.flushQue = 1'b1;
            ctl.flushE   = 1'b1;
            ctl.flushM   = 1'b1;
            if (iWait) begin
                ctl.stallF  = 1'b1;
                ctl.stallF2 = 1'b1;
                stateNxt    = pipeCtrlPkg::BRANCH_PEND;
            end
        end else if (eWait) begin
            // the queue keeps accepting from D while nothing dequeues into I
            ctl.stallIDe = 1'b1;
            ctl.stallE   = 1'b1;
            ctl.flushM   = 1'b1;            // nothing leaves E while the unit is busy
            if (overflowI) begin
                ctl.stallF  = 1'b1;
                ctl.stallF2 = 1'b1;
                ctl.stallF3 = 1'b1;
                ctl.stallD  = 1'b1;
                ctl.stallI  = 1'b1;
            end else if (iWait) begin
                ctl.stallF  = 1'b1;
                ctl.stallF2 = 1'b1;
                ctl.flushF3 = 1'b1;
            end
        end else if (overflowI) begin
            // the queue keeps draining into I
            ctl.stallF  = 1'b1;
            ctl.stallF2 = 1'b1;
            ctl.stallF3 = 1'b1;
            ctl.stallD  = 1'b1;
            ctl.stallI  = 1'b1;
        end else if (iWait) begin
            ctl.stallF  = 1'b1;
            ctl.stallF2 = 1'b1;
            ctl.flushF3 = 1'b1;
        end

        // once fetch runs again the stale front end is cleared one more time
        if (!ctl.stallF2 && state != pipeCtrlPkg::IDLE) begin
            ctl.flushF3 = 1'b1;
            ctl.flushD  = 1'b1;
            stateNxt    = pipeCtrlPkg::IDLE;
        end
    end

endmodule

// ==== design/pipeCtrlPkg.sv ====
package pipeCtrlPkg;

    // ##################################################
    // widths and fixed addresses
    // ##################################################
    localparam int PC_W        = 32;
    localparam int QUEUE_DEPTH = 4;                         // issue queue entries
    localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
    localparam int QCNT_W      = $clog2(QUEUE_DEPTH + 1);   // count has to reach a full queue

    typedef logic [PC_W-1:0]   pcT;
    typedef logic [QPTR_W-1:0] qPtrT;
    typedef logic [QCNT_W-1:0] qCntT;

    localparam pcT RESET_PC    = 32'h0000_1000;   // first fetch after reset
    localparam pcT EXCP_VECTOR = 32'h0000_0100;   // exceptions and interrupts land here
    localparam pcT PC_STEP     = 32'd4;

    // ##################################################
    // pipeline token and hazard strobes
    // ##################################################

    // one instruction as it travels down the pipe
    typedef struct packed {
        logic valid;
        pcT   pc;
    } stageTok;

    typedef struct packed {
        logic stallF;     // pc generator hold
        logic stallF2;
        logic flushF2;
        logic stallF3;
        logic flushF3;
        logic stallD;
        logic flushD;
        logic stallI;     // queue does not accept the D token
        logic stallIDe;   // queue does not dequeue into I
        logic flushI;
        logic flushQue;
        logic stallE;
        logic flushE;
        logic stallM;
        logic flushM;
        logic stallM2;
        logic flushM2;
        logic flushM3;
        logic flushW;
    } hazCtrl;

    typedef enum logic [1:0] {IDLE, EXCP_PEND, BRANCH_PEND} redirState;

    // next value of a stage register given its predecessor
    // prevGo low means the predecessor is held and only a bubble moves on
    function automatic stageTok stageNext(stageTok cur, stageTok prev, logic prevGo,
                                          logic stall, logic flush);
        stageTok nxt;
        nxt = cur;
        if (flush) begin
            nxt.valid = 1'b0;
        end else if (!stall) begin
            nxt.valid = prev.valid && prevGo;
            nxt.pc    = prev.pc;
        end
        return nxt;
    endfunction

endpackage

// ==== design/pipeTop.sv ====
`timescale 1ns/10ps

module pipeTop (
    input  logic            clk,
    input  logic            reset,
    input  logic            iWait,       // instruction memory not ready
    input  logic            dWait,       // data memory not ready
    input  logic            eWait,       // multi-cycle execute busy
    input  logic            irq,
    input  pipeCtrlPkg::pcT branchPc,
    input  pipeCtrlPkg::pcT branchTarget,
    input  pipeCtrlPkg::pcT excpPc,
    output logic            retireValid,
    output pipeCtrlPkg::pcT retirePc
);

    pipeCtrlPkg::hazCtrl  ctl;
    pipeCtrlPkg::stageTok f3Tok;
    pipeCtrlPkg::stageTok iTok;
    pipeCtrlPkg::pcT      redirPc;
    logic                 redirValid;
    logic                 branchM;
    logic                 excpM;
    logic                 excpW;
    logic                 overflowI;

    hazard u_hazard (
        .clk       (clk),
        .reset     (reset),
        .iWait     (iWait),
        .dWait     (dWait),
        .eWait     (eWait),
        .overflowI (overflowI),
        .branchM   (branchM),
        .excpM     (excpM),
        .excpW     (excpW),
        .ctl       (ctl)
    );

    fetchUnit u_fetchUnit (
        .clk        (clk),
        .reset      (reset),
        .ctl        (ctl),
        .redirValid (redirValid),
        .redirPc    (redirPc),
        .iWait      (iWait),
        .f3Tok      (f3Tok)
    );

    decodeIssue u_decodeIssue (
        .clk       (clk),
        .reset     (reset),
        .ctl       (ctl),
        .f3Tok     (f3Tok),
        .iTok      (iTok),
        .overflowI (overflowI)
    );

    backEnd u_backEnd (
        .clk          (clk),
        .reset        (reset),
        .ctl          (ctl),
        .iTok         (iTok),
        .branchPc     (branchPc),
        .branchTarget (branchTarget),
        .excpPc       (excpPc),
        .irq          (irq),
        .branchM      (branchM),
        .excpM        (excpM),
        .excpW        (excpW),
        .redirValid   (redirValid),
        .redirPc      (redirPc),
        .retireValid  (retireValid),
        .retirePc     (retirePc)
    );

endmodule

// ==== src.f ====
design/pipeCtrlPkg.sv
design/hazard.sv
design/fetchUnit.sv
design/decodeIssue.sv
design/backEnd.sv
design/pipeTop.sv
tb/hazard_props.sv
tb/pipeChecker.sv
tb/pipeTb.sv

// ==== tb/hazard_props.sv ====
`timescale 1ns/10ps

module hazardProps (
    input logic                   clk,
    input logic                   reset,
    input logic                   branchM,
    input logic                   excpM,
    input logic                   excpW,
    input pipeCtrlPkg::hazCtrl    ctl,
    input pipeCtrlPkg::redirState state
);

    logic redirect;     // any event that sends fetch somewhere else

    assign redirect = branchM || excpM || excpW;

    // a stage is never held and cleared in the same cycle outside a redirect
    noStallFlushClash: assert property (@(posedge clk) disable iff (reset)
        !redirect |-> !((ctl.stallF2 && ctl.flushF2) || (ctl.stallF3 && ctl.flushF3) ||
                        (ctl.stallD && ctl.flushD) || (ctl.stallI && ctl.flushI) ||
                        (ctl.stallE && ctl.flushE) || (ctl.stallM && ctl.flushM) ||
                        (ctl.stallM2 && ctl.flushM2)))
        else $error("stall and flush of one stage raised together without a redirect");

    pendingClears: assert property (@(posedge clk) disable iff (reset)
        (state != pipeCtrlPkg::IDLE && !ctl.stallF2) |=> state == pipeCtrlPkg::IDLE)
        else $error("pending redirect kept after fetch resumed");

    // the first cycle out of reset has an empty pipe and no waits
    quietAfterReset: assert property (@(posedge clk)
        $fell(reset) |-> (ctl == '0 && state == pipeCtrlPkg::IDLE))
        else $error("hazard strobes active right after reset");

endmodule

bind hazard hazardProps u_hazardProps (
    .clk     (clk),
    .reset   (reset),
    .branchM (branchM),
    .excpM   (excpM),
    .excpW   (excpW),
    .ctl     (ctl),
    .state   (state)
);

// ==== tb/pipeChecker.sv ====
`timescale 1ns/10ps

module pipeChecker (
    input  logic            clk,
    input  logic            reset,
    input  logic            retireValid,
    input  pipeCtrlPkg::pcT retirePc,
    input  logic            irq,
    input  pipeCtrlPkg::pcT branchPc,
    input  pipeCtrlPkg::pcT branchTarget,
    input  pipeCtrlPkg::pcT excpPc,
    output int              retired,
    output int              errors
);

    pipeCtrlPkg::pcT lastPc;
    logic            haveLast = 1'b0;   // nothing retired since reset
    logic            irqSeen  = 1'b0;   // an interrupt may replace the next retirement
    int              retireCnt = 0;
    int              errCnt    = 0;

    assign retired = retireCnt;
    assign errors  = errCnt;

    // compares one retired pc with the legal successor of the previous one
    task automatic checkRetire(input pipeCtrlPkg::pcT pc);
        pipeCtrlPkg::pcT expPc;
        if (!haveLast) begin
            expPc = pipeCtrlPkg::RESET_PC;
        end else if (lastPc == branchPc) begin
            expPc = branchTarget;                   // a taken branch skips to its target
        end else begin
            expPc = lastPc + pipeCtrlPkg::PC_STEP;
        end
        if (expPc == excpPc) begin
            expPc = pipeCtrlPkg::EXCP_VECTOR;       // faulting pc dies in M
        end
        if (irqSeen && pc == pipeCtrlPkg::EXCP_VECTOR) begin
            // interrupt taken, the W token it killed is the one missing
        end else if (pc != expPc) begin
            $display("[FAIL] %0t ns: retired pc %h, expected %h", $time, pc, expPc);
            errCnt++;
        end
        lastPc   = pc;
        haveLast = 1'b1;
        irqSeen  = 1'b0;
    endtask

    always @(posedge clk) begin
        if (reset) begin
            haveLast  = 1'b0;
            irqSeen   = 1'b0;
            retireCnt = 0;
        end else begin
            if (irq) begin
                irqSeen = 1'b1;
            end
            if (retireValid) begin
                checkRetire(retirePc);
                retireCnt++;
            end
        end
    end

endmodule

// ==== tb/pipeTb.sv ====
`timescale 1ns/10ps

module pipeTb;

    localparam int              NUM_TESTS      = 9;
    localparam int              TIMEOUT_CYCLES = 3000;
    localparam pipeCtrlPkg::pcT NO_PC          = 32'hFFFF_FFF0;  // never reached by the stream

    typedef struct packed {
        pipeCtrlPkg::pcT branchPc;
        pipeCtrlPkg::pcT branchTarget;
        pipeCtrlPkg::pcT excpPc;
        int              iProb;      // percent of cycles with the wait high
        int              dProb;
        int              eProb;
        int              irqCycle;   // negative means no interrupt
        int              retireN;
    } testRow;

    logic            clk;
    logic            reset;
    logic            iWait;
    logic            dWait;
    logic            eWait;
    logic            irq;
    pipeCtrlPkg::pcT branchPc;
    pipeCtrlPkg::pcT branchTarget;
    pipeCtrlPkg::pcT excpPc;
    logic            retireValid;
    pipeCtrlPkg::pcT retirePc;
    int              retired;
    int              errors;
    int              seed = 93104;
    testRow          tests [NUM_TESTS];

    pipeTop i_dut (
        .clk          (clk),
        .reset        (reset),
        .iWait        (iWait),
        .dWait        (dWait),
        .eWait        (eWait),
        .irq          (irq),
        .branchPc     (branchPc),
        .branchTarget (branchTarget),
        .excpPc       (excpPc),
        .retireValid  (retireValid),
        .retirePc     (retirePc)
    );

    pipeChecker u_checker (
        .clk          (clk),
        .reset        (reset),
        .retireValid  (retireValid),
        .retirePc     (retirePc),
        .irq          (irq),
        .branchPc     (branchPc),
        .branchTarget (branchTarget),
        .excpPc       (excpPc),
        .retired      (retired),
        .errors       (errors)
    );

    always #10 clk = ~clk;

    function automatic logic chance(int pct);
        int unsigned r;
        r = $unsigned($random(seed)) % 100;
        return r < pct;
    endfunction

    // ##################################################
    // stimulus table
    // ##################################################
    task automatic loadTable();
        tests[0] = '{NO_PC, NO_PC, NO_PC, 0, 0, 0, -1, 40};                      // plain stream
        tests[1] = '{NO_PC, NO_PC, NO_PC, 30, 20, 20, -1, 60};                   // random waits
        tests[2] = '{32'h0000_1020, 32'h0000_1080, NO_PC, 10, 0, 60, -1, 40};   // execute bursts
        tests[3] = '{32'h0000_1018, 32'h0000_1200, NO_PC, 0, 0, 0, -1, 20};
        tests[4] = '{32'h0000_1018, 32'h0000_1200, NO_PC, 50, 0, 0, -1, 20};    // fetch often waits
        tests[5] = '{NO_PC, NO_PC, 32'h0000_1024, 0, 0, 0, -1, 30};
        tests[6] = '{NO_PC, NO_PC, 32'h0000_1030, 30, 10, 10, -1, 30};
        tests[7] = '{NO_PC, NO_PC, NO_PC, 0, 0, 0, 20, 30};
        tests[8] = '{NO_PC, NO_PC, NO_PC, 20, 20, 20, 12, 30};
    endtask

    // reset the pipe with the row's configuration in place
    task automatic startTest(input testRow row);
        @(negedge clk);
        reset        = 1'b1;
        iWait        = 1'b0;
        dWait        = 1'b0;
        eWait        = 1'b0;
        irq          = 1'b0;
        branchPc     = row.branchPc;
        branchTarget = row.branchTarget;
        excpPc       = row.excpPc;
        repeat (2) @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic runRow(input testRow row, output logic done);
        int cyc;
        cyc  = 0;
        done = 1'b0;
        while (!done && cyc < TIMEOUT_CYCLES) begin
            @(negedge clk);
            if (retired >= row.retireN) begin
                done = 1'b1;
            end else begin
                iWait = chance(row.iProb);
                dWait = chance(row.dProb);
                eWait = chance(row.eProb);
                irq   = (cyc == row.irqCycle);  // one cycle pulse
                cyc++;
            end
        end
        iWait = 1'b0;
        dWait = 1'b0;
        eWait = 1'b0;
        irq   = 1'b0;
    endtask

    // ##################################################
    // test loop
    // ##################################################
    initial begin
        int   prevErrors;
        int   failedTests;
        int   testsRun;
        logic done;
        logic timedOut;
        clk          = 1'b0;
        reset        = 1'b1;
        iWait        = 1'b0;
        dWait        = 1'b0;
        eWait        = 1'b0;
        irq          = 1'b0;
        branchPc     = NO_PC;
        branchTarget = NO_PC;
        excpPc       = NO_PC;
        failedTests  = 0;
        testsRun     = 0;
        timedOut     = 1'b0;
        loadTable();
        for (int t = 0; t < NUM_TESTS && !timedOut; t++) begin
            prevErrors = errors;
            startTest(tests[t]);
            runRow(tests[t], done);
            testsRun++;
            if (!done) begin
                $display("test %0d timed out with %0d of %0d retirements", t, retired,
                         tests[t].retireN);
                timedOut = 1'b1;
                failedTests++;
            end else if (errors != prevErrors) begin
                $display("test %0d FAILED: %0d retired, %0d mismatches", t, retired,
                         errors - prevErrors);
                failedTests++;
            end else begin
                $display("test %0d ok: %0d retired, 0 mismatches", t, retired);
            end
        end
        $display("%0d tests run, %0d failed, %0d mismatches in total", testsRun, failedTests,
                 errors);
        if (timedOut || failedTests != 0) begin
            $display("tests failed");
        end else begin
            $display("all tests passed");
        end
        $finish;
    end

endmodule
